// ==== include/readout_defines.svh ====
`ifndef READOUT_DEFINES_SVH
`define READOUT_DEFINES_SVH

// data paths
`define RO_BYTE_W       8
`define RO_ADDR_W       32

// tcp loopback fifo
`define RO_FIFO_DEPTH   2048
`define RO_FIFO_CNT_W   11
// receive window, bits above the fill count read as ones
`define RO_WC_W         16

// fmc input pins per connector
`define RO_FMC_LA_W     17
`define RO_FMC_HB_W     8

// test pattern and heartbeat
`define RO_PAT_BIT      2
`define RO_TICK_CYCLES  1000

// build identification
`define RO_SYN_DATE     32'hA5C3_0F71
`define RO_FPGA_VER     8'h11

// remote bus register map
`define RO_REG_DATE0    32'h0000_0000
`define RO_REG_VER      32'h0000_0004
`define RO_REG_DIPSW    32'h0000_0005
`define RO_REG_SCRATCH  32'h0000_0006
`define RO_REG_FMC0     32'h0000_0008
`define RO_REG_FMC1     32'h0000_000C

`endif

// ==== src/readout_pkg.sv ====
`default_nettype none

`include "readout_defines.svh"

package readout_pkg;

  ////////////////////
  // payload types

  // one tcp or register data byte
  typedef logic [`RO_BYTE_W-1:0] byte_t;

  // remote bus address
  typedef logic [`RO_ADDR_W-1:0] rbcp_addr_t;

  // loopback fifo fill level
  typedef logic [`RO_FIFO_CNT_W-1:0] fifo_cnt_t;

  // captured fmc pins, la at the bottom, then hb, present flag on top
  typedef logic [`RO_FMC_LA_W+`RO_FMC_HB_W:0] fmc_in_t;

  // heartbeat tick divider
  typedef logic [$clog2(`RO_TICK_CYCLES)-1:0] tick_cnt_t;

endpackage

`default_nettype wire

// ==== src/tcp_loopback_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "readout_defines.svh"

module tcp_loopback_fifo (
  input  wire                     clk125_int,
  input  wire                     rst,
  input  wire                     tcp_open_i,
  input  wire logic               tcp_rx_wr_i,
  input  wire readout_pkg::byte_t tcp_rx_data_i,
  input  wire                     tcp_tx_full_i,
  output logic [`RO_WC_W-1:0]     tcp_rx_wc_o,
  output logic                    tcp_tx_wr_o,
  output readout_pkg::byte_t      tcp_tx_data_o
);

  import readout_pkg::*;

  localparam int PTR_W = $clog2(`RO_FIFO_DEPTH);
  // one slot kept free so the count fits the window field
  localparam fifo_cnt_t CNT_MAX = fifo_cnt_t'(`RO_FIFO_DEPTH - 1);

  byte_t            mem [`RO_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  fifo_cnt_t        count_q;
  fifo_cnt_t        fill;
  logic             full;
  logic             empty;
  logic             wr_en;
  logic             rd_en;
  logic             tx_valid_q;
  byte_t            tx_data_q;

  assign full  = (count_q == CNT_MAX);
  assign empty = (count_q == '0);

  // accept only on an open connection
  assign wr_en = tcp_open_i & tcp_rx_wr_i & ~full;
  // self pop, whenever tx side has room
  assign rd_en = tcp_open_i & ~empty & ~tcp_tx_full_i;

  ////////////////////
  // pointers and count

  always_ff @(posedge clk125_int) begin
    if (rst || !tcp_open_i) begin
      // closed connection drops whatever is pending
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      tx_valid_q <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // valid one cycle after the read
      tx_valid_q <= rd_en;
    end
  end

  ////////////////////
  // storage

  always_ff @(posedge clk125_int) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= tcp_rx_data_i;
    end
    if (rd_en) begin
      tx_data_q <= mem[rd_ptr_q];
    end
  end

  // window is the fill count, upper bits forced high
  assign fill          = tcp_open_i ? count_q : '0;
  assign tcp_rx_wc_o   = {{(`RO_WC_W-`RO_FIFO_CNT_W){1'b1}}, fill};
  assign tcp_tx_wr_o   = tx_valid_q & tcp_open_i;
  assign tcp_tx_data_o = tx_data_q;

  // sender must respect the window
  a_no_write_full: assert property (@(posedge clk125_int) disable iff (rst)
    (tcp_open_i && tcp_rx_wr_i) |-> !full)
    else $error("tcp write into full loopback fifo");

  // count tracks the pointer distance
  a_count_ptrs: assert property (@(posedge clk125_int) disable iff (rst)
    count_q == fifo_cnt_t'(wr_ptr_q - rd_ptr_q))
    else $error("loopback fifo count out of step with its pointers");

endmodule

`default_nettype wire

// ==== src/board_test_pattern.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "readout_defines.svh"

module board_test_pattern (
  input  wire  clk125_int,
  input  wire  rst,
  output logic test_toggle_o,
  output logic heartbeat_led_o
);

  import readout_pkg::*;

  localparam tick_cnt_t TICK_LAST = tick_cnt_t'(`RO_TICK_CYCLES - 1);

  logic [`RO_PAT_BIT:0] pat_cnt_q;
  tick_cnt_t            tick_cnt_q;
  logic                 tick;
  logic                 led_q;

  ////////////////////
  // pattern counter

  // only bits up to the toggle bit are kept
  always_ff @(posedge clk125_int) begin
    if (rst) begin
      pat_cnt_q <= '0;
    end else begin
      pat_cnt_q <= pat_cnt_q + 1'b1;
    end
  end

  assign test_toggle_o = pat_cnt_q[`RO_PAT_BIT];

  ////////////////////
  // heartbeat

  assign tick = (tick_cnt_q == TICK_LAST);

  always_ff @(posedge clk125_int) begin
    if (rst) begin
      tick_cnt_q <= '0;
      led_q      <= 1'b0;
    end else begin
      // wrap on the tick
      tick_cnt_q <= tick ? '0 : tick_cnt_q + 1'b1;
      if (tick) begin
        led_q <= ~led_q;
      end
    end
  end

  assign heartbeat_led_o = led_q;

endmodule

`default_nettype wire

// ==== src/rbcp_reg_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "readout_defines.svh"

module rbcp_reg_bank (
  input  wire                         clk125_int,
  input  wire                         rst,
  input  wire                         rbcp_act_i,
  input  wire readout_pkg::rbcp_addr_t rbcp_addr_i,
  input  wire                         rbcp_we_i,
  input  wire readout_pkg::byte_t     rbcp_wd_i,
  input  wire                         rbcp_re_i,
  input  wire readout_pkg::byte_t     dipsw_i,
  input  wire readout_pkg::fmc_in_t   fmc0_in_i,
  input  wire readout_pkg::fmc_in_t   fmc1_in_i,
  output logic                        rbcp_ack_o,
  output readout_pkg::byte_t          rbcp_rd_o
);

  import readout_pkg::*;

  localparam int         WORD_W       = 4 * `RO_BYTE_W;
  localparam rbcp_addr_t DATE_ADDR    = `RO_REG_DATE0;
  localparam rbcp_addr_t VER_ADDR     = `RO_REG_VER;
  localparam rbcp_addr_t DIPSW_ADDR   = `RO_REG_DIPSW;
  localparam rbcp_addr_t SCRATCH_ADDR = `RO_REG_SCRATCH;
  localparam rbcp_addr_t FMC0_ADDR    = `RO_REG_FMC0;
  localparam rbcp_addr_t FMC1_ADDR    = `RO_REG_FMC1;

  fmc_in_t           fmc0_meta_q;
  fmc_in_t           fmc0_sync_q;
  fmc_in_t           fmc1_meta_q;
  fmc_in_t           fmc1_sync_q;
  logic [WORD_W-1:0] fmc0_word;
  logic [WORD_W-1:0] fmc1_word;
  byte_t             scratch_q;
  byte_t             rd_mux;
  byte_t             rd_q;
  logic              ack_q;
  logic              wr_req;
  logic              rd_req;

  // byte idx of a 4-byte word, idx 0 at the bottom
  function automatic byte_t word_byte(input logic [WORD_W-1:0] word, input logic [1:0] idx);
    return word[idx*`RO_BYTE_W +: `RO_BYTE_W];
  endfunction

  ////////////////////
  // fmc pin capture

  // two stages, pins are asynchronous to clk125_int
  always_ff @(posedge clk125_int) begin
    fmc0_meta_q <= fmc0_in_i;
    fmc0_sync_q <= fmc0_meta_q;
    fmc1_meta_q <= fmc1_in_i;
    fmc1_sync_q <= fmc1_meta_q;
  end

  // unused top bits read 0
  assign fmc0_word = {{(WORD_W-$bits(fmc_in_t)){1'b0}}, fmc0_sync_q};
  assign fmc1_word = {{(WORD_W-$bits(fmc_in_t)){1'b0}}, fmc1_sync_q};

  ////////////////////
  // request decode

  // bus idle outside act
  assign wr_req = rbcp_act_i & rbcp_we_i;
  assign rd_req = rbcp_act_i & rbcp_re_i;

  always_comb begin
    rd_mux = '0;
    if (rbcp_addr_i[`RO_ADDR_W-1:2] == DATE_ADDR[`RO_ADDR_W-1:2]) begin
      // date goes out msb first
      rd_mux = word_byte(`RO_SYN_DATE, ~rbcp_addr_i[1:0]);
    end else if (rbcp_addr_i == VER_ADDR) begin
      rd_mux = `RO_FPGA_VER;
    end else if (rbcp_addr_i == DIPSW_ADDR) begin
      rd_mux = dipsw_i;
    end else if (rbcp_addr_i == SCRATCH_ADDR) begin
      rd_mux = scratch_q;
    end else if (rbcp_addr_i[`RO_ADDR_W-1:2] == FMC0_ADDR[`RO_ADDR_W-1:2]) begin
      rd_mux = word_byte(fmc0_word, rbcp_addr_i[1:0]);
    end else if (rbcp_addr_i[`RO_ADDR_W-1:2] == FMC1_ADDR[`RO_ADDR_W-1:2]) begin
      rd_mux = word_byte(fmc1_word, rbcp_addr_i[1:0]);
    end
  end

  // scratch is the only writable byte, other writes just get acked
  always_ff @(posedge clk125_int) begin
    if (rst) begin
      scratch_q <= '0;
      ack_q     <= 1'b0;
    end else begin
      if (wr_req && rbcp_addr_i == SCRATCH_ADDR) begin
        scratch_q <= rbcp_wd_i;
      end
      ack_q <= wr_req | rd_req;
    end
  end

  // read byte lines up with the ack
  always_ff @(posedge clk125_int) begin
    if (rd_req) begin
      rd_q <= rd_mux;
    end
  end

  assign rbcp_ack_o = ack_q;
  assign rbcp_rd_o  = rd_q;

  // stack never issues read and write at once
  a_we_re_excl: assert property (@(posedge clk125_int) disable iff (rst)
    !(rbcp_we_i && rbcp_re_i))
    else $error("rbcp we and re asserted together");

endmodule

`default_nettype wire

// ==== src/readout_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "readout_defines.svh"

module readout_top (
  input  wire                          clk125_int,
  input  wire                          rst,
  // tcp
  input  wire                          tcp_open_i,
  input  wire                          tcp_rx_wr_i,
  input  wire readout_pkg::byte_t      tcp_rx_data_i,
  input  wire                          tcp_tx_full_i,
  output logic [`RO_WC_W-1:0]          tcp_rx_wc_o,
  output logic                         tcp_tx_wr_o,
  output readout_pkg::byte_t           tcp_tx_data_o,
  // remote bus
  input  wire                          rbcp_act_i,
  input  wire readout_pkg::rbcp_addr_t rbcp_addr_i,
  input  wire                          rbcp_we_i,
  input  wire readout_pkg::byte_t      rbcp_wd_i,
  input  wire                          rbcp_re_i,
  output logic                         rbcp_ack_o,
  output readout_pkg::byte_t           rbcp_rd_o,
  // board io
  input  wire readout_pkg::byte_t      dipsw_i,
  input  wire [`RO_FMC_LA_W-1:0]       fmc0_la_n_i,
  input  wire [`RO_FMC_HB_W-1:0]       fmc0_hb_n_i,
  input  wire                          fmc0_prsnt_b_i,
  input  wire [`RO_FMC_LA_W-1:0]       fmc1_la_n_i,
  input  wire [`RO_FMC_HB_W-1:0]       fmc1_hb_n_i,
  input  wire                          fmc1_prsnt_b_i,
  output logic [`RO_FMC_LA_W-1:0]      fmc0_la_p_o,
  output logic [`RO_FMC_HB_W-1:0]      fmc0_hb_p_o,
  output logic [`RO_FMC_LA_W-1:0]      fmc1_la_p_o,
  output logic [`RO_FMC_HB_W-1:0]      fmc1_hb_p_o,
  output logic [3:0]                   testpin_o,
  output logic                         mmcx_test_p_o,
  output logic                         mmcx_test_n_o,
  output logic                         bled_b_o
);

  import readout_pkg::*;

  fmc_in_t fmc0_in;
  fmc_in_t fmc1_in;
  logic    test_toggle;
  logic    heartbeat_led;

  ////////////////////
  // tcp loopback

  tcp_loopback_fifo u_loopback (
    .clk125_int    (clk125_int),
    .rst           (rst),
    .tcp_open_i    (tcp_open_i),
    .tcp_rx_wr_i   (tcp_rx_wr_i),
    .tcp_rx_data_i (tcp_rx_data_i),
    .tcp_tx_full_i (tcp_tx_full_i),
    .tcp_rx_wc_o   (tcp_rx_wc_o),
    .tcp_tx_wr_o   (tcp_tx_wr_o),
    .tcp_tx_data_o (tcp_tx_data_o)
  );

  ////////////////////
  // slow control

  // la on the bottom, then hb, present flag on top
  assign fmc0_in = {fmc0_prsnt_b_i, fmc0_hb_n_i, fmc0_la_n_i};
  assign fmc1_in = {fmc1_prsnt_b_i, fmc1_hb_n_i, fmc1_la_n_i};

  rbcp_reg_bank u_regs (
    .clk125_int  (clk125_int),
    .rst         (rst),
    .rbcp_act_i  (rbcp_act_i),
    .rbcp_addr_i (rbcp_addr_i),
    .rbcp_we_i   (rbcp_we_i),
    .rbcp_wd_i   (rbcp_wd_i),
    .rbcp_re_i   (rbcp_re_i),
    .dipsw_i     (dipsw_i),
    .fmc0_in_i   (fmc0_in),
    .fmc1_in_i   (fmc1_in),
    .rbcp_ack_o  (rbcp_ack_o),
    .rbcp_rd_o   (rbcp_rd_o)
  );

  ////////////////////
  // pattern and led

  board_test_pattern u_pattern (
    .clk125_int      (clk125_int),
    .rst             (rst),
    .test_toggle_o   (test_toggle),
    .heartbeat_led_o (heartbeat_led)
  );

  // every test output follows the same toggle
  assign fmc0_la_p_o   = {`RO_FMC_LA_W{test_toggle}};
  assign fmc0_hb_p_o   = {`RO_FMC_HB_W{test_toggle}};
  assign fmc1_la_p_o   = {`RO_FMC_LA_W{test_toggle}};
  assign fmc1_hb_p_o   = {`RO_FMC_HB_W{test_toggle}};
  assign testpin_o     = {4{test_toggle}};
  // mmcx pair is driven as complements
  assign mmcx_test_p_o = test_toggle;
  assign mmcx_test_n_o = ~test_toggle;
  assign bled_b_o      = heartbeat_led;

endmodule

`default_nettype wire

// ==== tests/tb_readout_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "readout_defines.svh"

module tb_readout_top;

  import readout_pkg::*;

  localparam int N_BYTES   = 500;
  localparam int N_FAST    = 40;
  localparam int HB_CHECKS = 8;
  localparam int ACK_LIMIT = 8;
  localparam int CNT_W     = `RO_FIFO_CNT_W;
  // longest drain of a full fifo under no back-pressure
  localparam int DRAIN_LIMIT = 2 * `RO_FIFO_DEPTH;
  // loopback at about 8 cycles a byte, heartbeat window, slack for registers and close
  localparam int TIMEOUT_CYCLES = N_BYTES * 8 + HB_CHECKS * `RO_TICK_CYCLES + 8000;

  logic                    clk125_int;
  logic                    rst;
  logic                    tcp_open_i;
  logic                    tcp_rx_wr_i;
  byte_t                   tcp_rx_data_i;
  logic                    tcp_tx_full_i;
  logic [`RO_WC_W-1:0]     tcp_rx_wc_o;
  logic                    tcp_tx_wr_o;
  byte_t                   tcp_tx_data_o;
  logic                    rbcp_act_i;
  rbcp_addr_t              rbcp_addr_i;
  logic                    rbcp_we_i;
  byte_t                   rbcp_wd_i;
  logic                    rbcp_re_i;
  logic                    rbcp_ack_o;
  byte_t                   rbcp_rd_o;
  byte_t                   dipsw_i;
  logic [`RO_FMC_LA_W-1:0] fmc0_la_n_i;
  logic [`RO_FMC_HB_W-1:0] fmc0_hb_n_i;
  logic                    fmc0_prsnt_b_i;
  logic [`RO_FMC_LA_W-1:0] fmc1_la_n_i;
  logic [`RO_FMC_HB_W-1:0] fmc1_hb_n_i;
  logic                    fmc1_prsnt_b_i;
  logic [`RO_FMC_LA_W-1:0] fmc0_la_p_o;
  logic [`RO_FMC_HB_W-1:0] fmc0_hb_p_o;
  logic [`RO_FMC_LA_W-1:0] fmc1_la_p_o;
  logic [`RO_FMC_HB_W-1:0] fmc1_hb_p_o;
  logic [3:0]              testpin_o;
  logic                    mmcx_test_p_o;
  logic                    mmcx_test_n_o;
  logic                    bled_b_o;

  // reference model state
  byte_t       exp_q[$];
  int          tx_count;
  int          sent;
  int          cycle_cnt;
  int          hb_since;
  int          hb_changes;
  logic        hb_prev;
  logic [31:0] rng_state;

  readout_top DUT (.*);

  initial begin
    clk125_int = 1'b0;
    forever #4 clk125_int = ~clk125_int;
  end

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first failure");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_byte(input string what, input byte_t got, input byte_t exp);
    assert (got === exp)
      else stop_with_failure($sformatf("ERROR %0t: %s read 0x%02h, expected 0x%02h",
                                       $time, what, got, exp));
  endtask

  // one request pulse from a falling edge, rd is taken in the ack cycle
  task automatic rbcp_access(input rbcp_addr_t addr, input logic we, input byte_t wd,
                             output byte_t rd);
    int waited;
    rbcp_act_i  = 1'b1;
    rbcp_addr_i = addr;
    rbcp_we_i   = we;
    rbcp_re_i   = !we;
    rbcp_wd_i   = wd;
    @(negedge clk125_int);
    rbcp_we_i = 1'b0;
    rbcp_re_i = 1'b0;
    waited    = 0;
    while (!rbcp_ack_o && waited < ACK_LIMIT) begin
      @(negedge clk125_int);
      waited++;
    end
    assert (rbcp_ack_o)
      else stop_with_failure($sformatf("no ack came for the request to address 0x%08h", addr));
    rd = rbcp_rd_o;
    rbcp_act_i = 1'b0;
    // gap so every ack stands alone
    @(negedge clk125_int);
  endtask

  task automatic read_expect(input rbcp_addr_t addr, input byte_t exp, input string what);
    byte_t rd;
    rbcp_access(addr, 1'b0, 8'h00, rd);
    check_byte(what, rd, exp);
  endtask

  task automatic rbcp_write(input rbcp_addr_t addr, input byte_t wd);
    byte_t unused;
    rbcp_access(addr, 1'b1, wd, unused);
  endtask

  ////////////////////
  // loopback model

  // pop first, bytes written this cycle are never the ones leaving
  always @(posedge clk125_int) begin
    if (rst || !tcp_open_i) begin
      exp_q.delete();
    end else begin
      if (tcp_tx_wr_o) begin
        assert (exp_q.size() != 0)
          else stop_with_failure($sformatf("ERROR %0t: tx byte with nothing pending", $time));
        assert (tcp_tx_data_o === exp_q[0])
          else stop_with_failure($sformatf("ERROR %0t: tx byte 0x%02h, expected 0x%02h",
                                           $time, tcp_tx_data_o, exp_q[0]));
        void'(exp_q.pop_front());
        tx_count <= tx_count + 1;
      end
      if (tcp_rx_wr_i) begin
        exp_q.push_back(tcp_rx_data_i);
      end
    end
  end

  // empty fifo, no back-pressure, byte out two cycles after its write
  a_fast_return: assert property (@(posedge clk125_int) disable iff (rst)
    (tcp_open_i && tcp_rx_wr_i && tcp_rx_wc_o[CNT_W-1:0] == '0 && !tcp_tx_full_i)
    ##1 (tcp_open_i && !tcp_tx_full_i) |=> (tcp_tx_wr_o || !tcp_open_i))
    else stop_with_failure($sformatf("ERROR %0t: byte not back two cycles after write", $time));

  a_tx_after_room: assert property (@(posedge clk125_int) disable iff (rst)
    tcp_tx_wr_o |-> $past(!tcp_tx_full_i))
    else stop_with_failure($sformatf("ERROR %0t: tx byte read while tx was full", $time));

  a_closed_idle: assert property (@(posedge clk125_int) disable iff (rst)
    !tcp_open_i |-> (!tcp_tx_wr_o && tcp_rx_wc_o[CNT_W-1:0] == '0))
    else stop_with_failure($sformatf("ERROR %0t: loopback active while closed", $time));

  a_reopen_empty: assert property (@(posedge clk125_int) disable iff (rst)
    $rose(tcp_open_i) |-> tcp_rx_wc_o[CNT_W-1:0] == '0)
    else stop_with_failure($sformatf("ERROR %0t: window not empty after reopen", $time));

  a_window_upper: assert property (@(posedge clk125_int) disable iff (rst)
    tcp_rx_wc_o[`RO_WC_W-1:CNT_W] == '1)
    else stop_with_failure($sformatf("ERROR %0t: window upper bits not all ones", $time));

  ////////////////////
  // remote bus timing

  a_ack_follows: assert property (@(posedge clk125_int) disable iff (rst)
    (rbcp_act_i && (rbcp_we_i || rbcp_re_i)) |=> rbcp_ack_o)
    else stop_with_failure($sformatf("ERROR %0t: ack missing one cycle after request", $time));

  a_ack_has_req: assert property (@(posedge clk125_int) disable iff (rst)
    rbcp_ack_o |-> $past(rbcp_act_i && (rbcp_we_i || rbcp_re_i)))
    else stop_with_failure($sformatf("ERROR %0t: ack without a request", $time));

  a_ack_single: assert property (@(posedge clk125_int) disable iff (rst)
    rbcp_ack_o |=> !rbcp_ack_o)
    else stop_with_failure($sformatf("ERROR %0t: ack longer than one cycle", $time));

  ////////////////////
  // pattern, led, reset state

  a_reset_state: assert property (@(posedge clk125_int)
    $fell(rst) |-> (!tcp_tx_wr_o && !rbcp_ack_o && testpin_o == '0 && !bled_b_o))
    else stop_with_failure($sformatf("ERROR %0t: outputs not idle after reset", $time));

  // counter bit 2, low 4 then high 4
  a_toggle_start: assert property (@(posedge clk125_int)
    $fell(rst) |-> !mmcx_test_p_o [*4] ##1 mmcx_test_p_o [*4] ##1 !mmcx_test_p_o)
    else stop_with_failure($sformatf("ERROR %0t: toggle wrong after reset", $time));

  a_toggle_period: assert property (@(posedge clk125_int) disable iff (rst)
    $rose(mmcx_test_p_o) |-> mmcx_test_p_o [*4] ##1 !mmcx_test_p_o [*4] ##1 mmcx_test_p_o)
    else stop_with_failure($sformatf("ERROR %0t: toggle period not 8 cycles", $time));

  a_pins_equal: assert property (@(posedge clk125_int)
    fmc0_la_p_o == {`RO_FMC_LA_W{mmcx_test_p_o}} && fmc1_la_p_o == {`RO_FMC_LA_W{mmcx_test_p_o}}
    && fmc0_hb_p_o == {`RO_FMC_HB_W{mmcx_test_p_o}} && fmc1_hb_p_o == {`RO_FMC_HB_W{mmcx_test_p_o}}
    && testpin_o == {4{mmcx_test_p_o}} && mmcx_test_n_o == !mmcx_test_p_o)
    else stop_with_failure($sformatf("ERROR %0t: test outputs disagree", $time));

  // led change spacing counted in sampled cycles
  always @(posedge clk125_int) begin
    if (rst) begin
      hb_prev    <= 1'b0;
      hb_since   <= 0;
      hb_changes <= 0;
    end else if (bled_b_o !== hb_prev) begin
      assert (hb_since == `RO_TICK_CYCLES)
        else stop_with_failure($sformatf("ERROR %0t: led changed after %0d cycles",
                                         $time, hb_since));
      hb_prev    <= bled_b_o;
      hb_since   <= 1;
      hb_changes <= hb_changes + 1;
    end else begin
      hb_since <= hb_since + 1;
    end
  end

  always @(posedge clk125_int) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      stop_with_failure("timeout, the tests did not finish within the cycle limit");
    end
  end

  ////////////////////
  // stimulus

  initial begin
    logic [31:0] date_word;
    logic [31:0] fmc_word [2];
    byte_t       value;
    int          drain_wait;
    rng_state      = 32'd7392;
    cycle_cnt      = 0;
    tx_count       = 0;
    sent           = 0;
    rst            = 1'b1;
    tcp_open_i     = 1'b0;
    tcp_rx_wr_i    = 1'b0;
    tcp_rx_data_i  = '0;
    tcp_tx_full_i  = 1'b0;
    rbcp_act_i     = 1'b0;
    rbcp_addr_i    = '0;
    rbcp_we_i      = 1'b0;
    rbcp_wd_i      = '0;
    rbcp_re_i      = 1'b0;
    dipsw_i        = '0;
    fmc0_la_n_i    = '0;
    fmc0_hb_n_i    = '0;
    fmc0_prsnt_b_i = 1'b0;
    fmc1_la_n_i    = '0;
    fmc1_hb_n_i    = '0;
    fmc1_prsnt_b_i = 1'b0;
    repeat (5) @(negedge clk125_int);
    rst = 1'b0;
    @(negedge clk125_int);

    // register map, scratch first while still at reset value
    read_expect(`RO_REG_SCRATCH, 8'h00, "scratch after reset");
    date_word = `RO_SYN_DATE;
    for (int i = 0; i < 4; i++) begin
      read_expect(`RO_REG_DATE0 + i, date_word[8*(3-i) +: 8], "date byte");
    end
    read_expect(`RO_REG_VER, `RO_FPGA_VER, "version");
    rng_state = xorshift32(rng_state);
    dipsw_i   = rng_state[7:0];
    read_expect(`RO_REG_DIPSW, dipsw_i, "dip switches");
    rng_state = xorshift32(rng_state);
    value     = rng_state[7:0];
    rbcp_write(`RO_REG_SCRATCH, value);
    read_expect(`RO_REG_SCRATCH, value, "scratch");
    // read-only, write must leave it alone
    rbcp_write(`RO_REG_VER, ~`RO_FPGA_VER);
    read_expect(`RO_REG_VER, `RO_FPGA_VER, "version after write");
    read_expect(32'h0000_0007, 8'h00, "unmapped 0x07");
    read_expect(32'h0000_0010, 8'h00, "unmapped 0x10");
    read_expect(32'h0001_0004, 8'h00, "unmapped 0x10004");

    // pin capture, la then hb then present, lsb first
    repeat (2) begin
      rng_state      = xorshift32(rng_state);
      fmc0_la_n_i    = rng_state[16:0];
      fmc0_hb_n_i    = rng_state[24:17];
      fmc0_prsnt_b_i = rng_state[31];
      rng_state      = xorshift32(rng_state);
      fmc1_la_n_i    = rng_state[16:0];
      fmc1_hb_n_i    = rng_state[24:17];
      fmc1_prsnt_b_i = rng_state[31];
      fmc_word[0]    = {6'b0, fmc0_prsnt_b_i, fmc0_hb_n_i, fmc0_la_n_i};
      fmc_word[1]    = {6'b0, fmc1_prsnt_b_i, fmc1_hb_n_i, fmc1_la_n_i};
      repeat (3) @(negedge clk125_int);
      for (int i = 0; i < 4; i++) begin
        read_expect(`RO_REG_FMC0 + i, fmc_word[0][8*i +: 8], "fmc0 capture");
        read_expect(`RO_REG_FMC1 + i, fmc_word[1][8*i +: 8], "fmc1 capture");
      end
    end

    // loopback, sparse writes into an empty fifo first
    tcp_open_i = 1'b1;
    @(negedge clk125_int);
    while (sent < N_FAST) begin
      rng_state     = xorshift32(rng_state);
      tcp_rx_wr_i   = 1'b1;
      tcp_rx_data_i = rng_state[7:0];
      sent++;
      @(negedge clk125_int);
      tcp_rx_wr_i = 1'b0;
      repeat (3) @(negedge clk125_int);
    end
    // random back-pressure, sender honours the window
    while (sent < N_BYTES) begin
      rng_state     = xorshift32(rng_state);
      tcp_tx_full_i = rng_state[4];
      tcp_rx_wr_i   = rng_state[0] && (tcp_rx_wc_o[CNT_W-1:0] < `RO_FIFO_DEPTH - 2);
      tcp_rx_data_i = rng_state[15:8];
      if (tcp_rx_wr_i) begin
        sent++;
      end
      @(negedge clk125_int);
    end
    tcp_rx_wr_i   = 1'b0;
    tcp_tx_full_i = 1'b0;
    drain_wait    = 0;
    while (exp_q.size() != 0 && drain_wait < DRAIN_LIMIT) begin
      @(negedge clk125_int);
      drain_wait++;
    end
    @(negedge clk125_int);
    assert (exp_q.size() == 0 && tx_count == N_BYTES)
      else stop_with_failure($sformatf("ERROR %0t: %0d bytes returned, expected %0d",
                                       $time, tx_count, N_BYTES));

    // leave bytes pending, then close with one byte in flight
    tcp_tx_full_i = 1'b1;
    repeat (6) begin
      rng_state     = xorshift32(rng_state);
      tcp_rx_wr_i   = 1'b1;
      tcp_rx_data_i = rng_state[7:0];
      @(negedge clk125_int);
    end
    tcp_rx_wr_i   = 1'b0;
    tcp_tx_full_i = 1'b0;
    @(negedge clk125_int);
    tcp_open_i = 1'b0;
    repeat (4) @(negedge clk125_int);
    tcp_open_i = 1'b1;
    repeat (10) @(negedge clk125_int);
    assert (tx_count == N_BYTES && exp_q.size() == 0)
      else stop_with_failure($sformatf("ERROR %0t: bytes survived the close", $time));

    // heartbeat watch window
    repeat (HB_CHECKS * `RO_TICK_CYCLES) @(negedge clk125_int);
    if (hb_changes < HB_CHECKS) begin
      stop_with_failure("heartbeat led did not change often enough");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
src/readout_pkg.sv
src/tcp_loopback_fifo.sv
src/board_test_pattern.sv
src/rbcp_reg_bank.sv
src/readout_top.sv
tests/tb_readout_top.sv
